// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_memory_pipe_arbiter
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: arbiter_matching_queue.sv
`include "mem_pipe_settings.svh"

module arbiter_matching_queue #(
	parameter int DEPTH = `MEM_PIPE_QUEUE_DEPTH,
	parameter int DEPTH_N = `MEM_PIPE_QUEUE_DEPTH_N
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic push,
	input mem_pipe_pkg::mem_side_t push_side,
	output logic full,
	input logic pop,
	output logic head_valid,
	output mem_pipe_pkg::mem_side_t head_side
);
	import mem_pipe_pkg::*;

	localparam logic [DEPTH_N-1:0] LAST_PTR = DEPTH_N'(DEPTH - 1);
	localparam logic [DEPTH_N:0] FULL_COUNT = (DEPTH_N + 1)'(DEPTH);

	mem_side_t side_mem [DEPTH];
	logic [DEPTH_N-1:0] wr_ptr;
	logic [DEPTH_N-1:0] rd_ptr;
	logic [DEPTH_N:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == FULL_COUNT);
	assign head_valid = (count != '0);
	assign head_side = side_mem[rd_ptr];

	// Never overrun or underrun, whatever the callers do
	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	always_ff @(posedge iCLOCK) begin
		if (do_push) begin
			side_mem[wr_ptr] <= push_side;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			// All outstanding tags are dropped at once
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: core_request_mux.sv
module core_request_mux (
	input logic iCLOCK,
	input logic inRESET,
	// Load/store side
	input logic data_req,
	input mem_pipe_pkg::data_req_t data_req_info,
	output logic data_lock,
	// Fetch side
	input logic inst_req,
	input mem_pipe_pkg::inst_req_t inst_req_info,
	output logic inst_lock,
	// Back pressure
	input logic mem_lock,
	input logic queue_full,
	input logic flush,
	// Issue register towards memory
	output logic mem_req,
	output mem_pipe_pkg::mem_req_t mem_req_info,
	// Order queue write
	output logic push,
	output mem_pipe_pkg::mem_side_t push_side
);
	import mem_pipe_pkg::*;

	logic common_lock;
	logic data_sel;
	logic inst_sel;
	logic accept;
	mem_req_t next_info;

	assign common_lock = queue_full || mem_lock;

	// Data always wins, a fetch only goes when no data request is up
	assign data_sel = data_req;
	assign inst_sel = !data_req && inst_req;

	assign data_lock = common_lock || inst_sel;
	assign inst_lock = common_lock || data_req;

	assign accept = !common_lock && (data_sel || inst_sel);

	always_comb begin
		if (data_sel) begin
			next_info = '{
				store_ack: data_req_info.rw,
				order: data_req_info.order,
				rw: data_req_info.rw,
				mmu_mode: data_req_info.mmu_mode,
				pdt: data_req_info.pdt,
				addr: data_req_info.addr,
				data: data_req_info.data
			};
		end else begin
			// Fetch is always a read with no write data
			next_info = '{
				store_ack: 1'b0,
				order: ORDER_FETCH,
				rw: 1'b0,
				mmu_mode: inst_req_info.mmu_mode,
				pdt: inst_req_info.pdt,
				addr: inst_req_info.addr,
				data: 32'h0
			};
		end
	end

	// Stores get an ack from memory and never occupy a queue slot
	assign push = accept && !(data_sel && data_req_info.rw);
	assign push_side = data_sel ? SIDE_DATA : SIDE_INST;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mem_req <= 1'b0;
		end else if (flush) begin
			mem_req <= 1'b0;
		end else if (!common_lock) begin
			mem_req <= data_sel || inst_sel;
		end
	end

	// Fields only load on acceptance, otherwise they hold
	always_ff @(posedge iCLOCK) begin
		if (flush) begin
			mem_req_info <= '0;
		end else if (accept) begin
			mem_req_info <= next_info;
		end
	end

endmodule

// File: list.f
+incdir+.
mem_pipe_pkg.sv
arbiter_matching_queue.sv
core_request_mux.sv
mem_response_router.sv
memory_pipe_arbiter.sv
memory_pipe_chk.sv
tb_memory_pipe_arbiter.sv

// File: mem_pipe_pkg.sv
package mem_pipe_pkg;

	// Which core port a request or reply belongs to
	typedef enum logic {
		SIDE_INST = 1'b0,
		SIDE_DATA = 1'b1
	} mem_side_t;

	// Order code the memory sees for every instruction fetch
	localparam logic [1:0] ORDER_FETCH = 2'd2;

	// Load/store request from the core
	typedef struct packed {
		logic [1:0] order;
		logic rw;
		logic [1:0] mmu_mode;
		logic [31:0] pdt;
		logic [31:0] addr;
		logic [31:0] data;
	} data_req_t;

	// Fetch request, order and data are implied
	typedef struct packed {
		logic [1:0] mmu_mode;
		logic [31:0] pdt;
		logic [31:0] addr;
	} inst_req_t;

	// Request as it leaves for memory
	typedef struct packed {
		// Set for data writes, the memory answers with an ack only
		logic store_ack;
		logic [1:0] order;
		logic rw;
		logic [1:0] mmu_mode;
		logic [31:0] pdt;
		logic [31:0] addr;
		logic [31:0] data;
	} mem_req_t;

	// Reply from memory, also the shape of both core reply ports
	typedef struct packed {
		logic pagefault;
		logic [63:0] data;
		logic [27:0] mmu_flags;
	} mem_rsp_t;

endpackage

// File: mem_pipe_settings.svh
`ifndef MEM_PIPE_SETTINGS_SVH
`define MEM_PIPE_SETTINGS_SVH

// Outstanding reads the order queue can track
`define MEM_PIPE_QUEUE_DEPTH 16

// Pointer width for that depth
`define MEM_PIPE_QUEUE_DEPTH_N 4

`endif

// File: mem_response_router.sv
module mem_response_router (
	input logic iCLOCK,
	input logic inRESET,
	// Reply from memory
	input logic mem_valid,
	input logic mem_store_ack,
	input logic mem_queue_flush,
	input mem_pipe_pkg::mem_rsp_t mem_rsp_info,
	// Order queue read
	input logic head_valid,
	input mem_pipe_pkg::mem_side_t head_side,
	output logic pop,
	// Core stall inputs
	input logic inst_busy,
	input logic data_busy,
	output logic mem_busy,
	// Fetch reply port
	output logic inst_valid,
	output logic inst_queue_flush,
	output mem_pipe_pkg::mem_rsp_t inst_rsp_info,
	// Load/store reply port
	output logic data_valid,
	output mem_pipe_pkg::mem_rsp_t data_rsp_info
);
	import mem_pipe_pkg::*;

	logic read_rsp;
	logic rsp_inst;
	logic rsp_data;
	logic inst_valid_q;

	// Memory holds off its replies while either core port is stalled
	assign mem_busy = data_busy || inst_busy;

	assign read_rsp = mem_valid && !mem_store_ack && head_valid;
	assign rsp_inst = read_rsp && (head_side == SIDE_INST);
	assign rsp_data = (mem_valid && mem_store_ack) || (read_rsp && (head_side == SIDE_DATA));

	// A fetch reply is only consumed when the fetch register can take it
	assign pop = read_rsp && ((head_side == SIDE_DATA) || !inst_busy);

	// Fetch side, frozen while the core is busy
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_valid_q <= 1'b0;
		end else if (!inst_busy) begin
			inst_valid_q <= rsp_inst;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!inst_busy && rsp_inst) begin
			inst_rsp_info <= mem_rsp_info;
		end
	end

	// Flush notice is forwarded even when the fetch port is stalled
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			inst_queue_flush <= 1'b0;
		end else begin
			inst_queue_flush <= mem_queue_flush;
		end
	end

	assign inst_valid = inst_valid_q && !inst_busy;

	// Data side takes read replies and store acks alike
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			data_valid <= 1'b0;
		end else begin
			data_valid <= rsp_data;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rsp_data) begin
			data_rsp_info <= mem_rsp_info;
		end
	end

endmodule

// File: memory_pipe_arbiter.sv
module memory_pipe_arbiter (
	input logic iCLOCK,
	input logic inRESET,
	// Load/store requests from the core
	input logic data_req,
	input mem_pipe_pkg::data_req_t data_req_info,
	output logic data_lock,
	// Load/store replies to the core
	output logic data_valid,
	input logic data_busy,
	output mem_pipe_pkg::mem_rsp_t data_rsp_info,
	// Fetch requests from the core
	input logic inst_req,
	input mem_pipe_pkg::inst_req_t inst_req_info,
	output logic inst_lock,
	// Fetch replies to the core
	output logic inst_valid,
	input logic inst_busy,
	output logic inst_queue_flush,
	output mem_pipe_pkg::mem_rsp_t inst_rsp_info,
	// Memory request port
	output logic mem_req,
	input logic mem_lock,
	output mem_pipe_pkg::mem_req_t mem_req_info,
	// Memory reply port
	input logic mem_valid,
	output logic mem_busy,
	input logic mem_store_ack,
	input logic mem_queue_flush,
	input mem_pipe_pkg::mem_rsp_t mem_rsp_info
);
	import mem_pipe_pkg::*;

	// Order queue handshake
	logic queue_full;
	logic push;
	mem_side_t push_side;
	logic pop;
	logic head_valid;
	mem_side_t head_side;

	core_request_mux u_req_mux (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.data_req(data_req),
		.data_req_info(data_req_info),
		.data_lock(data_lock),
		.inst_req(inst_req),
		.inst_req_info(inst_req_info),
		.inst_lock(inst_lock),
		.mem_lock(mem_lock),
		.queue_full(queue_full),
		.flush(mem_queue_flush),
		.mem_req(mem_req),
		.mem_req_info(mem_req_info),
		.push(push),
		.push_side(push_side)
	);

	// Side tag per outstanding read, in issue order
	arbiter_matching_queue u_match_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(mem_queue_flush),
		.push(push),
		.push_side(push_side),
		.full(queue_full),
		.pop(pop),
		.head_valid(head_valid),
		.head_side(head_side)
	);

	mem_response_router u_rsp_router (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_valid(mem_valid),
		.mem_store_ack(mem_store_ack),
		.mem_queue_flush(mem_queue_flush),
		.mem_rsp_info(mem_rsp_info),
		.head_valid(head_valid),
		.head_side(head_side),
		.pop(pop),
		.inst_busy(inst_busy),
		.data_busy(data_busy),
		.mem_busy(mem_busy),
		.inst_valid(inst_valid),
		.inst_queue_flush(inst_queue_flush),
		.inst_rsp_info(inst_rsp_info),
		.data_valid(data_valid),
		.data_rsp_info(data_rsp_info)
	);

endmodule

// File: memory_pipe_chk.sv
module memory_pipe_chk (
	input logic iCLOCK,
	input logic inRESET,
	input logic data_req,
	input logic inst_req,
	input logic data_lock,
	input logic inst_lock,
	input logic mem_req,
	input logic mem_queue_flush,
	input logic data_valid,
	input logic inst_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Set once any property below has failed
	bit fired = 1'b0;

	// Flush clears the issue register
	a_no_req_after_flush: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_queue_flush |=> !mem_req)
		else begin
			$error("mem_req high in the cycle after a flush");
			fired = 1'b1;
		end

	// At most one side may be accepted
	a_one_side: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(data_req && inst_req) |-> (data_lock || inst_lock))
		else begin
			$error("both locks low with both requests present");
			fired = 1'b1;
		end

	a_valid_known: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!$isunknown({data_valid, inst_valid}))
		else begin
			$error("reply valid is unknown after reset");
			fired = 1'b1;
		end

endmodule

bind memory_pipe_arbiter memory_pipe_chk u_chk (.*);

// File: tb_memory_pipe_arbiter.sv
`include "mem_pipe_settings.svh"

module tb_memory_pipe_arbiter;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pipe_pkg::*;

	localparam int RUN_CYCLES = 4000;
	localparam int DRAIN_LIMIT = 600;

	logic iCLOCK;
	logic inRESET;
	logic data_req;
	data_req_t data_req_info;
	logic data_lock;
	logic data_valid;
	logic data_busy;
	mem_rsp_t data_rsp_info;
	logic inst_req;
	inst_req_t inst_req_info;
	logic inst_lock;
	logic inst_valid;
	logic inst_busy;
	logic inst_queue_flush;
	mem_rsp_t inst_rsp_info;
	logic mem_req;
	logic mem_lock;
	mem_req_t mem_req_info;
	logic mem_valid;
	logic mem_busy;
	logic mem_store_ack;
	logic mem_queue_flush;
	mem_rsp_t mem_rsp_info;

	// Reference model state
	int qcount;
	int cyc;
	bit flush_now;
	bit flush_prev;
	bit exp_req_valid;
	bit exp_mem_req;
	mem_req_t exp_req;
	mem_side_t exp_req_side;
	bit data_acc_prev;
	bit inst_acc_prev;
	bit pop_now;
	bit issue_data;
	bit issue_inst;
	mem_rsp_t issue_rsp;
	bit data_exp_valid;
	mem_rsp_t data_exp;
	mem_rsp_t inst_q[$];
	// Requests the memory model has seen on the port in issue order
	bit pend_store[$];
	mem_side_t pend_side[$];
	bit full_seen;
	bit held_seen;
	bit flush_seen;

	memory_pipe_arbiter u_dut (.*);

	always #2 iCLOCK = ~iCLOCK;

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
		if (got !== exp) begin
			$display("FAIL mem_req_info got %h expected %h", got, exp);
			stop_run();
		end
	endtask

	task automatic check_rsp(input mem_side_t side, input mem_rsp_t got, input mem_rsp_t exp);
		if (got !== exp) begin
			$display("FAIL %s_rsp_info got %h expected %h",
				(side == SIDE_DATA) ? "data" : "inst", got, exp);
			stop_run();
		end
	endtask

	task automatic drive_inputs(input bit allow_new);
		bit stalled;
		stalled = allow_new && ((cyc % 256) < 80);
		// Accepted requests leave and held ones stay
		if (data_acc_prev) data_req = 1'b0;
		if (inst_acc_prev) inst_req = 1'b0;
		if (allow_new && !data_req && ($urandom % 3 == 0)) begin
			data_req = 1'b1;
			data_req_info.order = 2'($urandom);
			data_req_info.rw = ($urandom % 4 == 0);
			data_req_info.mmu_mode = 2'($urandom);
			data_req_info.pdt = $urandom;
			data_req_info.addr = $urandom;
			data_req_info.data = $urandom;
		end
		if (allow_new && !inst_req && ($urandom % 2 == 0)) begin
			inst_req = 1'b1;
			inst_req_info.mmu_mode = 2'($urandom);
			inst_req_info.pdt = $urandom;
			inst_req_info.addr = $urandom;
		end
		mem_lock = allow_new && ($urandom % 8 == 0);
		inst_busy = ($urandom % 5 == 0);
		data_busy = ($urandom % 9 == 0);
		flush_now = allow_new && ($urandom % 150 == 0);
		mem_queue_flush = flush_now;
		mem_valid = 1'b0;
		mem_store_ack = 1'b0;
		issue_data = 1'b0;
		issue_inst = 1'b0;
		pop_now = 1'b0;
		issue_rsp.pagefault = 1'($urandom);
		issue_rsp.data = {$urandom, $urandom};
		issue_rsp.mmu_flags = 28'($urandom);
		mem_rsp_info = issue_rsp;
		// Memory answers in order and never while busy
		if (!flush_now && !inst_busy && !data_busy && pend_side.size() > 0 && !stalled
				&& ($urandom % 2 == 0)) begin
			mem_valid = 1'b1;
			mem_store_ack = pend_store[0];
			issue_data = pend_store[0] || (pend_side[0] == SIDE_DATA);
			issue_inst = !issue_data;
			pop_now = !pend_store[0];
			void'(pend_store.pop_front());
			void'(pend_side.pop_front());
		end
	endtask

	task automatic check_cycle();
		bit common;
		bit exp_iv;
		bit data_acc;
		bit inst_acc;
		if (u_dut.u_chk.fired) begin
			$display("A protocol assertion on the arbiter ports failed");
			stop_run();
		end
		check_bit("mem_busy", mem_busy, data_busy || inst_busy);
		check_bit("inst_queue_flush", inst_queue_flush, flush_prev);
		// Issue register holds its level and fields under the common lock
		check_bit("mem_req", mem_req, exp_mem_req);
		if (exp_mem_req) begin
			check_mem_req(mem_req_info, exp_req);
		end
		// Only a fresh issue is new work for the memory
		if (exp_req_valid && !flush_now) begin
			pend_store.push_back(exp_req.store_ack);
			pend_side.push_back(exp_req_side);
		end
		if (flush_now) begin
			pend_store.delete();
			pend_side.delete();
			flush_seen = 1'b1;
		end
		common = mem_lock || (qcount == `MEM_PIPE_QUEUE_DEPTH);
		if (qcount == `MEM_PIPE_QUEUE_DEPTH) full_seen = 1'b1;
		check_bit("data_lock", data_lock, common || (inst_req && !data_req));
		check_bit("inst_lock", inst_lock, common || data_req);
		check_bit("data_valid", data_valid, data_exp_valid);
		if (data_exp_valid) check_rsp(SIDE_DATA, data_rsp_info, data_exp);
		exp_iv = (inst_q.size() > 0) && !inst_busy;
		if (inst_q.size() > 0 && inst_busy) held_seen = 1'b1;
		check_bit("inst_valid", inst_valid, exp_iv);
		if (exp_iv) begin
			check_rsp(SIDE_INST, inst_rsp_info, inst_q[0]);
			void'(inst_q.pop_front());
		end
		data_acc = data_req && !common;
		inst_acc = inst_req && !data_req && !common;
		// Requests taken in a flush cycle are dropped
		exp_req_valid = (data_acc || inst_acc) && !flush_now;
		if (data_acc) begin
			exp_req.store_ack = data_req_info.rw;
			exp_req.order = data_req_info.order;
			exp_req.rw = data_req_info.rw;
			exp_req.mmu_mode = data_req_info.mmu_mode;
			exp_req.pdt = data_req_info.pdt;
			exp_req.addr = data_req_info.addr;
			exp_req.data = data_req_info.data;
			exp_req_side = SIDE_DATA;
		end else if (inst_acc) begin
			exp_req.store_ack = 1'b0;
			exp_req.order = ORDER_FETCH;
			exp_req.rw = 1'b0;
			exp_req.mmu_mode = inst_req_info.mmu_mode;
			exp_req.pdt = inst_req_info.pdt;
			exp_req.addr = inst_req_info.addr;
			exp_req.data = 32'h0;
			exp_req_side = SIDE_INST;
		end
		if (flush_now) begin
			exp_mem_req = 1'b0;
		end else if (!common) begin
			exp_mem_req = exp_req_valid;
		end
		if (flush_now) begin
			qcount = 0;
		end else begin
			qcount = qcount + int'(exp_req_valid && !exp_req.store_ack) - int'(pop_now);
		end
		data_exp_valid = issue_data;
		data_exp = issue_rsp;
		if (issue_inst) inst_q.push_back(issue_rsp);
		flush_prev = flush_now;
		data_acc_prev = data_acc;
		inst_acc_prev = inst_acc;
	endtask

	task automatic run_cycle(input bit allow_new);
		@(negedge iCLOCK);
		drive_inputs(allow_new);
		#1;
		check_cycle();
		cyc++;
	endtask

	initial begin
		int wait_cnt;
		void'($urandom(32'h7ad2_6981));
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		data_req = 1'b0;
		data_req_info = '0;
		data_busy = 1'b0;
		inst_req = 1'b0;
		inst_req_info = '0;
		inst_busy = 1'b0;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_store_ack = 1'b0;
		mem_queue_flush = 1'b0;
		mem_rsp_info = '0;
		qcount = 0;
		cyc = 0;
		repeat (8) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		for (int i = 0; i < RUN_CYCLES; i++) begin
			run_cycle(1'b1);
		end
		// Let the memory answer everything still in flight
		wait_cnt = 0;
		while (pend_side.size() > 0 || inst_q.size() > 0 || data_exp_valid || exp_req_valid
				|| data_req || inst_req) begin
			if (wait_cnt == DRAIN_LIMIT) begin
				$display("Timeout while draining outstanding requests and replies");
				stop_run();
			end
			run_cycle(1'b0);
			wait_cnt++;
		end
		if (!full_seen || !held_seen || !flush_seen) begin
			$display("Run never reached a full queue, a held fetch reply or a flush");
			$display("CHECKS FAILED");
			$fatal(1, "scenario not covered");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule
